// File: filelist.f
hdl/blast_mem_pkg.sv
hdl/blast_seq_pkg.sv
hdl/blast_command_decode.sv
hdl/sequence_streamer.sv
hdl/memory_read_sequencer.sv
hdl/hit_record_writer.sv
hdl/blast_controller_top.sv
tests/blast_memory_model.sv
tests/blast_controller_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       ?= blast_controller_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT := all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q -x "$(PASS_TEXT)" $(LOG); then \
		echo "simulation result: PASS"; \
	else \
		echo "simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/blast_controller_tb.sv
`timescale 1ns/10ps
`default_nettype none

module blast_controller_tb;
   import blast_mem_pkg::*;
   import blast_seq_pkg::*;

   localparam mem_addr_t  QUERY_ADDR   = MEM_QUERY_ADDR;
   localparam mem_addr_t  SUBJECT_ADDR = MEM_SUBJECT_ADDR;
   localparam mem_addr_t  HIT_ADDR     = MEM_HIT_SCORE_ADDR;
   localparam mem_count_t SUBJECT_ID   = 32'h0051_d7a3;
   localparam mem_count_t SUBJECT_LEN  = 32'd200;
   // about twice one query plus ten subject blocks
   localparam int TIMEOUT_CYCLES = 3000;

   logic        clk = 1'b0;
   logic        reset;
   logic        app_ready;
   app_code_t   app_code;
   mem_word_t   memory_readdata;
   mem_addr_t   memory_address;
   logic        memory_write;
   mem_word_t   memory_writedata;
   logic        query_enable;
   nt_char_t    query_char;
   logic        subject_enable;
   nt_char_t    subject_char;
   logic        array_clear;
   logic        hit_read;
   hit_field_t  hit_query_pos;
   hit_field_t  hit_subject_pos;
   hit_field_t  hit_length;
   hit_field_t  hit_score;

   logic [31:0] hit_list [0:1023];
   logic [9:0]  hit_index;
   int          cycle_count;
   int          error_count;
   int          check_count;
   int          test_count;
   int unsigned seed_value;

   always #2 clk = ~clk;

   blast_controller_top #(
      .MEM_QUERY_ADDR     (QUERY_ADDR),
      .MEM_SUBJECT_ADDR   (SUBJECT_ADDR),
      .MEM_HIT_SCORE_ADDR (HIT_ADDR)
   ) u_dut (
      .clk              (clk),
      .reset            (reset),
      .app_ready        (app_ready),
      .app_code         (app_code),
      .memory_readdata  (memory_readdata),
      .memory_address   (memory_address),
      .memory_write     (memory_write),
      .memory_writedata (memory_writedata),
      .query_enable     (query_enable),
      .query_char       (query_char),
      .subject_enable   (subject_enable),
      .subject_char     (subject_char),
      .array_clear      (array_clear),
      .hit_read         (hit_read),
      .hit_query_pos    (hit_query_pos),
      .hit_subject_pos  (hit_subject_pos),
      .hit_length       (hit_length),
      .hit_score        (hit_score)
   );

   blast_memory_model u_mem (
      .clk       (clk),
      .address   (memory_address),
      .write     (memory_write),
      .writedata (memory_writedata),
      .readdata  (memory_readdata)
   );

   // array stand-in, one record per hit_read cycle
   initial begin
      hit_query_pos   = '0;
      hit_subject_pos = '0;
      hit_length      = '0;
      hit_score       = '0;
      hit_index       = '0;
      forever begin
         @(posedge clk);
         #0.5;
         if (hit_read) begin
            {hit_query_pos, hit_subject_pos, hit_length, hit_score} = hit_list[hit_index];
            hit_index = hit_index + 10'd1;
         end else begin
            {hit_query_pos, hit_subject_pos, hit_length, hit_score} = '0;
         end
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
   end

   task automatic compare_value(input logic [63:0] got, input logic [63:0] expected,
                                input string what);
      check_count++;
      assert (got == expected) else begin
         $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
         error_count++;
      end
   endtask

   task automatic report_test(input string name, input int start_errors);
      test_count++;
      if (error_count == start_errors) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, error_count - start_errors);
      end
   endtask

   function automatic mem_count_t byte_reverse(input mem_count_t value);
      return {value[7:0], value[15:8], value[23:16], value[31:24]};
   endfunction

   // six query words, lowest bits first
   function automatic nt_char_t query_char_at(input int idx);
      logic [383:0] window;
      window = {u_mem.mem[QUERY_ADDR + 14'd5], u_mem.mem[QUERY_ADDR + 14'd4],
                u_mem.mem[QUERY_ADDR + 14'd3], u_mem.mem[QUERY_ADDR + 14'd2],
                u_mem.mem[QUERY_ADDR + 14'd1], u_mem.mem[QUERY_ADDR]};
      return nt_char_t'(window >> (3 * idx));
   endfunction

   // block k streams data words 3k-2 to 3k, data word 1 follows the header
   function automatic nt_char_t subject_char_at(input int block, input int idx);
      mem_addr_t    first;
      logic [191:0] window;
      first  = mem_addr_t'(int'(SUBJECT_ADDR) + 3 * block - 2);
      window = {u_mem.mem[first + 14'd2], u_mem.mem[first + 14'd1], u_mem.mem[first]};
      return nt_char_t'(window >> (3 * idx));
   endfunction

   // eight bytes per word read until length plus one block is covered
   function automatic int window_count_for(input mem_count_t length);
      int words;
      int windows;
      words   = 7;
      windows = 1;
      while (8 * words < length + 64) begin
         words   = words + 3;
         windows = windows + 1;
      end
      return windows;
   endfunction

   task automatic build_hit_list();
      for (int i = 0; i < 1024; i++) begin
         // empty slots mixed in
         if (i % 3 == 0 || i % 5 == 2) begin
            hit_list[10'(i)] = '0;
         end else begin
            hit_list[10'(i)] = $urandom | 32'd1;
         end
      end
   endtask

   task automatic fill_memory();
      for (int a = 0; a < (1 << $bits(mem_addr_t)); a++) begin
         u_mem.mem[mem_addr_t'(a)] = {$urandom, $urandom};
      end
      // subject header, length byte-reversed
      u_mem.mem[SUBJECT_ADDR] = {SUBJECT_ID, byte_reverse(SUBJECT_LEN)};
   endtask

   task automatic send_command(input app_code_t code);
      @(posedge clk);
      #0.5;
      app_ready = 1'b1;
      app_code  = code;
      @(posedge clk);
      #0.5;
      app_ready = 1'b0;
      app_code  = '0;
   endtask

   task automatic check_quiet(input int cycles, input string what);
      repeat (cycles) begin
         @(negedge clk);
         compare_value(64'({query_enable, subject_enable, memory_write, hit_read, array_clear}),
                       64'd0, what);
      end
   endtask

   task automatic idle_after_reset(input string name);
      int start_errors;
      start_errors = error_count;
      check_quiet(20, "outputs after reset");
      report_test(name, start_errors);
   endtask

   task automatic ignore_unknown_code(input string name);
      int start_errors;
      start_errors = error_count;
      send_command(8'h5c);
      check_quiet(20, "outputs after unknown code");
      report_test(name, start_errors);
   endtask

   task automatic query_stream(input string name);
      int start_errors;
      int chars;
      int clears;
      int wait_cycles;
      int first_cycle;
      bit done;
      start_errors = error_count;
      chars        = 0;
      clears       = 0;
      wait_cycles  = 0;
      first_cycle  = 0;
      done         = 1'b0;
      send_command(READ_QUERY_CODE);
      while (!done) begin
         @(negedge clk);
         wait_cycles++;
         if (array_clear) begin
            clears++;
         end
         if (query_enable) begin
            if (chars == 0) begin
               first_cycle = wait_cycles;
            end
            compare_value(64'(query_char), 64'(query_char_at(chars)),
                          $sformatf("query char %0d", chars));
            chars++;
         end else if (chars > 0) begin
            done = 1'b1;
         end
      end
      compare_value(64'(chars), 64'(QUERY_CHARS), "query character count");
      compare_value(64'(clears), 64'd1, "array_clear pulses");
      // six read cycles, stream on the seventh
      compare_value(64'(first_cycle), 64'd7, "first query character cycle");
      report_test(name, start_errors);
   endtask

   task automatic subject_run(input string name);
      int        start_errors;
      int        chars;
      int        block;
      int        windows;
      int        window_len;
      int        hits;
      int        writes_before;
      bit        header_seen;
      mem_addr_t hit_addr;
      mem_word_t hit_word;
      start_errors  = error_count;
      chars         = 0;
      block         = 1;
      windows       = 0;
      window_len    = 0;
      hits          = 0;
      header_seen   = 1'b0;
      hit_addr      = HIT_ADDR + 14'd1;
      writes_before = u_mem.write_count;
      send_command(READ_SUBJECT_CODE);
      while (!header_seen) begin
         @(negedge clk);
         if (subject_enable) begin
            compare_value(64'(subject_char), 64'(subject_char_at(block, chars)),
                          $sformatf("block %0d char %0d", block, chars));
            chars++;
         end else if (chars > 0) begin
            compare_value(64'(chars), 64'(BLOCK_CHARS),
                          $sformatf("block %0d character count", block));
            chars = 0;
            block++;
         end
         if (hit_read) begin
            window_len++;
            hit_word = {32'd0, hit_query_pos, hit_subject_pos, hit_length, hit_score};
            compare_value(64'(memory_write), 64'(hit_word != '0), "hit write strobe");
            if (hit_word != '0) begin
               compare_value(64'(memory_address), 64'(hit_addr), "hit write address");
               compare_value(memory_writedata, hit_word, "hit write data");
               hits++;
               // top address wraps past the summary slot
               hit_addr = (hit_addr == '1) ? HIT_ADDR + 14'd1 : hit_addr + 14'd1;
            end
         end else begin
            if (window_len > 0) begin
               compare_value(64'(window_len), 64'(HIT_WINDOW_CYCLES), "hit window length");
               window_len = 0;
               windows++;
            end
            if (memory_write) begin
               compare_value(64'(memory_address), 64'(HIT_ADDR), "summary address");
               compare_value(memory_writedata,
                             {SUBJECT_ID, byte_reverse(mem_count_t'(hits))}, "summary data");
               header_seen = 1'b1;
            end
         end
      end
      compare_value(64'(windows), 64'(window_count_for(SUBJECT_LEN)), "hit window count");
      compare_value(64'(block - 1), 64'(windows), "streamed block count");
      @(posedge clk);
      #0.5;
      compare_value(u_mem.mem[HIT_ADDR], {SUBJECT_ID, byte_reverse(mem_count_t'(hits))},
                    "summary word in memory");
      compare_value(64'(u_mem.write_count - writes_before), 64'(hits + 1),
                    "memory write count");
      report_test(name, start_errors);
   endtask

   initial begin
      reset       = 1'b1;
      app_ready   = 1'b0;
      app_code    = '0;
      error_count = 0;
      check_count = 0;
      test_count  = 0;
      seed_value  = $urandom(32'h8529_3715);
      build_hit_list();
      fill_memory();
      repeat (8) @(posedge clk);
      #0.5;
      reset = 1'b0;

      idle_after_reset("idle after reset");
      ignore_unknown_code("unknown command ignored");
      query_stream("query stream");
      subject_run("subject blocks and hits");
      // back in idle, a new query must be taken
      query_stream("query after subject");

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/blast_memory_model.sv
`timescale 1ns/10ps
`default_nettype none

module blast_memory_model (
   input  wire                           clk,
   input  wire blast_mem_pkg::mem_addr_t address,
   input  wire                           write,
   input  wire blast_mem_pkg::mem_word_t writedata,
   output blast_mem_pkg::mem_word_t      readdata
);
   import blast_mem_pkg::*;

   localparam int DEPTH = 1 << $bits(mem_addr_t);

   // preloaded from the testbench before reset
   mem_word_t mem [0:DEPTH-1];

   // write capture
   int        write_count = 0;

   // asynchronous read, data valid in the same cycle
   assign readdata = mem[address];

   always @(posedge clk) begin
      if (write) begin
         mem[address]       <= writedata;
         write_count        <= write_count + 1;
      end
   end

endmodule

`default_nettype wire

// File: hdl/blast_controller_top.sv
`timescale 1ns/10ps
`default_nettype none

module blast_controller_top #(
   parameter blast_mem_pkg::mem_addr_t MEM_QUERY_ADDR     = blast_mem_pkg::MEM_QUERY_ADDR,
   parameter blast_mem_pkg::mem_addr_t MEM_SUBJECT_ADDR   = blast_mem_pkg::MEM_SUBJECT_ADDR,
   parameter blast_mem_pkg::mem_addr_t MEM_HIT_SCORE_ADDR = blast_mem_pkg::MEM_HIT_SCORE_ADDR
) (
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            app_ready,
   input  wire blast_seq_pkg::app_code_t  app_code,
   input  wire blast_mem_pkg::mem_word_t  memory_readdata,
   output wire blast_mem_pkg::mem_addr_t  memory_address,
   output wire                            memory_write,
   output wire blast_mem_pkg::mem_word_t  memory_writedata,
   output wire                            query_enable,
   output wire blast_seq_pkg::nt_char_t   query_char,
   output wire                            subject_enable,
   output wire blast_seq_pkg::nt_char_t   subject_char,
   output wire                            array_clear,
   output wire                            hit_read,
   input  wire blast_seq_pkg::hit_field_t hit_query_pos,
   input  wire blast_seq_pkg::hit_field_t hit_subject_pos,
   input  wire blast_seq_pkg::hit_field_t hit_length,
   input  wire blast_seq_pkg::hit_field_t hit_score
);
   import blast_mem_pkg::*;
   import blast_seq_pkg::*;

   phase_t     phase;
   logic       query_done;
   logic       subject_done;
   logic       subject_finished;
   logic       window_done;
   logic       header_done;
   mem_addr_t  read_address;
   logic       query_load;
   logic       subject_load;
   logic       subject_upper;
   mem_count_t subject_id;

   blast_command_decode u_decode (
      .clk              (clk),
      .reset            (reset),
      .app_ready        (app_ready),
      .app_code         (app_code),
      .query_done       (query_done),
      .subject_done     (subject_done),
      .subject_finished (subject_finished),
      .window_done      (window_done),
      .header_done      (header_done),
      .phase            (phase),
      .array_clear      (array_clear)
   );

   memory_read_sequencer #(
      .QUERY_BASE   (MEM_QUERY_ADDR),
      .SUBJECT_BASE (MEM_SUBJECT_ADDR)
   ) u_sequencer (
      .clk              (clk),
      .reset            (reset),
      .phase            (phase),
      .memory_readdata  (memory_readdata),
      .read_address     (read_address),
      .query_load       (query_load),
      .subject_load     (subject_load),
      .subject_upper    (subject_upper),
      .query_done       (query_done),
      .subject_done     (subject_done),
      .subject_finished (subject_finished),
      .subject_id       (subject_id)
   );

   // query window is always loaded whole
   sequence_streamer #(
      .STREAM_CHARS (QUERY_CHARS)
   ) u_query_streamer (
      .clk         (clk),
      .reset       (reset),
      .word_load   (query_load),
      .load_upper  (1'b0),
      .load_word   (memory_readdata),
      .char_enable (query_enable),
      .char_out    (query_char)
   );

   sequence_streamer #(
      .STREAM_CHARS (BLOCK_CHARS)
   ) u_subject_streamer (
      .clk         (clk),
      .reset       (reset),
      .word_load   (subject_load),
      .load_upper  (subject_upper),
      .load_word   (memory_readdata),
      .char_enable (subject_enable),
      .char_out    (subject_char)
   );

   hit_record_writer #(
      .HIT_BASE (MEM_HIT_SCORE_ADDR)
   ) u_writer (
      .clk              (clk),
      .reset            (reset),
      .phase            (phase),
      .read_address     (read_address),
      .subject_id       (subject_id),
      .hit_query_pos    (hit_query_pos),
      .hit_subject_pos  (hit_subject_pos),
      .hit_length       (hit_length),
      .hit_score        (hit_score),
      .hit_read         (hit_read),
      .window_done      (window_done),
      .header_done      (header_done),
      .memory_address   (memory_address),
      .memory_write     (memory_write),
      .memory_writedata (memory_writedata)
   );

endmodule

`default_nettype wire

// File: hdl/hit_record_writer.sv
`timescale 1ns/10ps
`default_nettype none

module hit_record_writer #(
   parameter blast_mem_pkg::mem_addr_t HIT_BASE = blast_mem_pkg::MEM_HIT_SCORE_ADDR
) (
   input  wire                             clk,
   input  wire                             reset,
   input  wire blast_seq_pkg::phase_t      phase,
   input  wire blast_mem_pkg::mem_addr_t   read_address,
   input  wire blast_mem_pkg::mem_count_t  subject_id,
   input  wire blast_seq_pkg::hit_field_t  hit_query_pos,
   input  wire blast_seq_pkg::hit_field_t  hit_subject_pos,
   input  wire blast_seq_pkg::hit_field_t  hit_length,
   input  wire blast_seq_pkg::hit_field_t  hit_score,
   output logic                            hit_read,
   output logic                            window_done,
   output logic                            header_done,
   output blast_mem_pkg::mem_addr_t        memory_address,
   output logic                            memory_write,
   output blast_mem_pkg::mem_word_t        memory_writedata
);
   import blast_mem_pkg::*;
   import blast_seq_pkg::*;

   localparam int WINDOW_W = $clog2(HIT_WINDOW_CYCLES);

   logic [WINDOW_W-1:0] window_count;
   mem_addr_t           hit_addr;
   mem_count_t          hit_count;
   logic                in_window;
   logic                in_header;
   logic                hit_found;

   assign in_window = (phase == write_hits);
   assign in_header = (phase == write_header);
   assign hit_found = |{hit_query_pos, hit_subject_pos, hit_length, hit_score};

   assign hit_read    = in_window;
   assign window_done = in_window && (window_count == WINDOW_W'(HIT_WINDOW_CYCLES - 1));
   assign header_done = in_header;

   // all-zero records are empty slots
   assign memory_write = (in_window && hit_found) || in_header;

   always_comb begin
      if (in_window) begin
         memory_address   = hit_addr;
         memory_writedata = {32'd0, hit_query_pos, hit_subject_pos, hit_length, hit_score};
      end else if (in_header) begin
         memory_address   = HIT_BASE;
         memory_writedata = {subject_id, hit_count[7:0], hit_count[15:8],
                             hit_count[23:16], hit_count[31:24]};
      end else begin
         memory_address   = read_address;
         memory_writedata = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || phase == idle) begin
         window_count <= '0;
         hit_addr     <= HIT_BASE + 1'b1;
         hit_count    <= '0;
      end else if (in_window) begin
         window_count <= window_done ? '0 : window_count + 1'b1;
         if (hit_found) begin
            hit_count <= hit_count + 1'b1;
            // base slot is kept for the summary
            if (hit_addr == '1) begin
               hit_addr <= HIT_BASE + 1'b1;
            end else begin
               hit_addr <= hit_addr + 1'b1;
            end
         end
      end
   end

   // hit records never overwrite the summary slot
   a_hit_not_on_base: assert property (@(posedge clk) disable iff (reset)
      (memory_write && in_window) |-> (memory_address != HIT_BASE));

   // the window closes on its last cycle
   a_window_closes: assert property (@(posedge clk) disable iff (reset)
      window_done |=> (phase != write_hits));

endmodule

`default_nettype wire

// File: hdl/memory_read_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module memory_read_sequencer #(
   parameter blast_mem_pkg::mem_addr_t QUERY_BASE   = blast_mem_pkg::MEM_QUERY_ADDR,
   parameter blast_mem_pkg::mem_addr_t SUBJECT_BASE = blast_mem_pkg::MEM_SUBJECT_ADDR
) (
   input  wire                           clk,
   input  wire                           reset,
   input  wire blast_seq_pkg::phase_t    phase,
   input  wire blast_mem_pkg::mem_word_t memory_readdata,
   output blast_mem_pkg::mem_addr_t      read_address,
   output logic                          query_load,
   output logic                          subject_load,
   output logic                          subject_upper,
   output logic                          query_done,
   output logic                          subject_done,
   output logic                          subject_finished,
   output blast_mem_pkg::mem_count_t     subject_id
);
   import blast_mem_pkg::*;
   import blast_seq_pkg::*;

   // last word index of each read burst
   localparam logic [2:0] QUERY_LAST = 3'(WINDOW_WORDS - 1);
   localparam logic [2:0] FIRST_LAST = 3'(WINDOW_WORDS);
   localparam logic [2:0] LATER_LAST = 3'(WINDOW_WORDS / 2 - 1);

   logic [2:0] word_count;
   logic       first_block;
   mem_addr_t  query_addr;
   mem_addr_t  subject_addr;
   mem_count_t subject_length;
   mem_count_t subject_total;
   logic       header_word;

   // word 0 of the first block is the subject header
   assign header_word = (phase == read_subject) && first_block && (word_count == '0);

   assign read_address  = (phase == read_query) ? query_addr : subject_addr;
   assign query_load    = (phase == read_query);
   assign subject_load  = (phase == read_subject) && !header_word;
   assign subject_upper = !first_block;

   assign query_done   = (phase == read_query) && (word_count == QUERY_LAST);
   assign subject_done = (phase == read_subject) &&
                         (word_count == (first_block ? FIRST_LAST : LATER_LAST));

   // one block of slack past the stated length
   assign subject_finished = (subject_total >= subject_length + 32'd64);

   always_ff @(posedge clk) begin
      if (reset || phase == idle) begin
         word_count    <= '0;
         first_block   <= 1'b1;
         query_addr    <= QUERY_BASE;
         subject_addr  <= SUBJECT_BASE;
         subject_total <= '0;
      end else begin
         case (phase)
            read_query: begin
               query_addr <= query_addr + 1'b1;
               word_count <= query_done ? 3'd0 : word_count + 1'b1;
            end
            read_subject: begin
               subject_addr  <= subject_addr + 1'b1;
               // eight bytes per word, header included
               subject_total <= subject_total + 32'd8;
               if (subject_done) begin
                  word_count  <= '0;
                  first_block <= 1'b0;
               end else begin
                  word_count <= word_count + 1'b1;
               end
            end
            default: begin
            end
         endcase
      end
   end

   // header: id on top, length stored byte-reversed below
   always_ff @(posedge clk) begin
      if (header_word) begin
         subject_id     <= memory_readdata[63:32];
         subject_length <= {memory_readdata[7:0], memory_readdata[15:8],
                            memory_readdata[23:16], memory_readdata[31:24]};
      end
   end

endmodule

`default_nettype wire

// File: hdl/sequence_streamer.sv
`timescale 1ns/10ps
`default_nettype none

module sequence_streamer #(
   parameter int STREAM_CHARS = blast_seq_pkg::QUERY_CHARS
) (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          word_load,
   input  wire                          load_upper,
   input  wire blast_mem_pkg::mem_word_t load_word,
   output logic                         char_enable,
   output blast_seq_pkg::nt_char_t      char_out
);
   import blast_mem_pkg::*;
   import blast_seq_pkg::*;

   localparam int WORD_BITS   = $bits(mem_word_t);
   localparam int WINDOW_BITS = WINDOW_WORDS * WORD_BITS;
   localparam int HALF_BITS   = WINDOW_BITS / 2;
   localparam int CHAR_BITS   = $bits(nt_char_t);
   localparam int COUNT_W     = $clog2(STREAM_CHARS);

   logic [WINDOW_BITS-1:0] window;
   logic                   pending;
   logic [COUNT_W-1:0]     char_count;
   logic                   last_char;

   // stream as soon as loading pauses
   assign char_enable = pending && !word_load;
   assign char_out    = window[CHAR_BITS-1:0];
   assign last_char   = (char_count == COUNT_W'(STREAM_CHARS - 1));

   // oldest word at the bottom, characters leave from bit 0
   always_ff @(posedge clk) begin
      if (word_load) begin
         if (load_upper) begin
            window[WINDOW_BITS-1:HALF_BITS] <=
               {load_word, window[WINDOW_BITS-1:HALF_BITS+WORD_BITS]};
         end else begin
            window <= {load_word, window[WINDOW_BITS-1:WORD_BITS]};
         end
      end else if (char_enable) begin
         window <= {{CHAR_BITS{1'b0}}, window[WINDOW_BITS-1:CHAR_BITS]};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pending    <= 1'b0;
         char_count <= '0;
      end else if (word_load) begin
         pending    <= 1'b1;
         char_count <= '0;
      end else if (char_enable) begin
         if (last_char) begin
            pending    <= 1'b0;
            char_count <= '0;
         end else begin
            char_count <= char_count + 1'b1;
         end
      end
   end

   // new words must not land in a window that is half streamed
   a_load_after_drain: assert property (@(posedge clk) disable iff (reset)
      word_load |-> (char_count == '0));

endmodule

`default_nettype wire

// File: hdl/blast_command_decode.sv
`timescale 1ns/10ps
`default_nettype none

module blast_command_decode (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          app_ready,
   input  wire blast_seq_pkg::app_code_t app_code,
   input  wire                          query_done,
   input  wire                          subject_done,
   input  wire                          subject_finished,
   input  wire                          window_done,
   input  wire                          header_done,
   output blast_seq_pkg::phase_t        phase,
   output logic                         array_clear
);
   import blast_seq_pkg::*;

   phase_t next_phase;

   always_comb begin
      next_phase = phase;
      case (phase)
         idle: begin
            // strobe only counts here, unknown codes fall through
            if (app_ready && app_code == READ_QUERY_CODE) begin
               next_phase = read_query;
            end else if (app_ready && app_code == READ_SUBJECT_CODE) begin
               next_phase = read_subject;
            end
         end
         read_query: begin
            if (query_done) begin
               next_phase = idle;
            end
         end
         read_subject: begin
            if (subject_done) begin
               next_phase = write_hits;
            end
         end
         write_hits: begin
            if (window_done) begin
               next_phase = subject_finished ? write_header : read_subject;
            end
         end
         write_header: begin
            if (header_done) begin
               next_phase = idle;
            end
         end
         default: next_phase = idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         phase       <= idle;
         array_clear <= 1'b0;
      end else begin
         phase       <= next_phase;
         // new query wipes the array
         array_clear <= (phase == idle) && app_ready && (app_code == READ_QUERY_CODE);
      end
   end

   // each done flag belongs to exactly one phase
   a_done_in_phase: assert property (@(posedge clk) disable iff (reset)
      (!query_done || phase == read_query) &&
      (!subject_done || phase == read_subject) &&
      (!window_done || phase == write_hits) &&
      (!header_done || phase == write_header));

endmodule

`default_nettype wire

// File: hdl/blast_seq_pkg.sv
`default_nettype none

package blast_seq_pkg;

   // one nucleotide character
   typedef logic [2:0] nt_char_t;

   // one field of a hit record from the array
   typedef logic [7:0] hit_field_t;

   // host command code
   typedef logic [7:0] app_code_t;

   localparam app_code_t READ_QUERY_CODE   = 8'hAA;
   localparam app_code_t READ_SUBJECT_CODE = 8'hBB;

   // controller phases
   typedef enum logic [2:0] {
      idle,
      read_query,
      read_subject,
      write_hits,
      write_header
   } phase_t;

   // characters per query and per subject block
   localparam int QUERY_CHARS = 128;
   localparam int BLOCK_CHARS = 64;

   // one cycle longer than a block stream so the last hit can drain
   localparam int HIT_WINDOW_CYCLES = 65;

endpackage

`default_nettype wire

// File: hdl/blast_mem_pkg.sv
`default_nettype none

package blast_mem_pkg;

   // one memory word address and one memory word
   typedef logic [13:0] mem_addr_t;
   typedef logic [63:0] mem_word_t;

   // subject length, subject id and hit total
   typedef logic [31:0] mem_count_t;

   // both the query and the subject window hold six words
   localparam int WINDOW_WORDS = 6;

   // database block size in words (127 KiB of 64-bit words)
   localparam int DATABASE_BLOCK_SIZE = 16250;

   // memory map
   localparam mem_addr_t MEM_QUERY_ADDR   = 14'd0;
   localparam mem_addr_t MEM_SUBJECT_ADDR = 14'd12;
   // hit area sits right after the subject block
   localparam mem_addr_t MEM_HIT_SCORE_ADDR =
      mem_addr_t'(MEM_SUBJECT_ADDR + DATABASE_BLOCK_SIZE);

endpackage

`default_nettype wire
